//--- Makefile
TOP := tb_top

all: run

run:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- design/pipe_mask_ctrl.sv
module pipe_mask_ctrl (
   input  logic                                             aggre_clk,
   input  logic                                             rst_n,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               data_vld,
   input  logic [vsm_ctrl_pkg::NUM_PIPES*vsm_hdr_pkg::REC_W-1:0] rd_data,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               pipe_concat_en,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               force_video_mask,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               auto_mask_en,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               video_mask_restart,
   input  logic                                             video_mask_latch_reset,
   input  logic [vsm_hdr_pkg::DT_W-1:0]                     ref_datatype,
   input  logic [vsm_hdr_pkg::WC_W-1:0]                     ref_wordcount,
   input  logic [vsm_hdr_pkg::LC_W-1:0]                     ref_linecount,
   input  logic                                             check_linecount_en,
   input  logic                                             end_sch_pulse,
   output logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               rd_en,
   output logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               mem_clear,
   output logic                                             start_sch_pulse,
   output logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               pipe_mask_bitmap,
   output logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               video_status_pass_bitmap
);
   import vsm_hdr_pkg::*;
   import vsm_ctrl_pkg::*;

   logic [NUM_PIPES-1:0] force_m;                        // Masks gated by concat enable
   logic [NUM_PIPES-1:0] auto_en;
   logic [NUM_PIPES-1:0] restart;
   logic [NUM_PIPES-1:0] pass_now;                       // Check result this cycle
   logic [NUM_PIPES-1:0] auto_latch;                     // Sticky auto-mask
   logic [NUM_PIPES-1:0] latch_set;
   logic [NUM_PIPES-1:0] latch_clr;
   logic [NUM_PIPES-1:0] latch_nxt;

   // ========================================
   // Register gating and pop
   // ========================================
   assign force_m = pipe_concat_en & force_video_mask;
   assign auto_en = pipe_concat_en & auto_mask_en;
   assign restart = pipe_concat_en & video_mask_restart;

   // Pop every enabled pipe that has a head entry
   assign rd_en   = {NUM_PIPES{end_sch_pulse}} & pipe_concat_en & data_vld;

   // ========================================
   // Per-pipe record check
   // ========================================
   for (genvar i = 0; i < NUM_PIPES; i++) begin : g_chk
      logic [REC_W-1:0] rec;
      logic             dt_ok;
      logic             wc_ok;
      logic             lc_ok;

      assign rec   = rd_data[i*REC_W +: REC_W];          // This pipe's head word
      assign dt_ok = (rec[DT_LSB +: DT_W] == ref_datatype);
      assign wc_ok = (rec[WC_LSB +: WC_W] == ref_wordcount);
      assign lc_ok = ~check_linecount_en ||
                     (rec[LC_LSB +: LC_W] == ref_linecount);  // Optional check

      // Popped and all fields good
      assign pass_now[i] = rd_en[i] & dt_ok & wc_ok & lc_ok;
   end

   // ========================================
   // Auto-mask latch
   // ========================================
   always_comb begin
      // Empty FIFO at schedule time counts as a failure too
      latch_set = {NUM_PIPES{end_sch_pulse}} & auto_en & ~pass_now;
      latch_clr = restart | {NUM_PIPES{video_mask_latch_reset}};
      latch_nxt = (auto_latch | latch_set) & ~latch_clr;   // Clear beats set
   end

   always_ff @(posedge aggre_clk) begin
      if (!rst_n) begin
         auto_latch <= '0;
         mem_clear  <= '0;
      end else begin
         auto_latch <= latch_nxt;
         mem_clear  <= latch_nxt & ~auto_latch;          // One pulse on the rise
      end
   end

   // ========================================
   // Start pulse and bitmaps
   // ========================================
   always_ff @(posedge aggre_clk) begin
      if (!rst_n) begin
         start_sch_pulse          <= 1'b0;
         pipe_mask_bitmap         <= '0;
         video_status_pass_bitmap <= '0;
      end else begin
         start_sch_pulse <= end_sch_pulse;               // Fixed one-cycle latency
         if (end_sch_pulse) begin                        // Hold between schedules
            pipe_mask_bitmap         <= force_m | latch_nxt;
            video_status_pass_bitmap <= pass_now;
         end
      end
   end

endmodule

//--- design/status_capture.sv
module status_capture (
   input  logic                          aggre_clk,
   input  logic                          rst_n,
   input  logic                          header_en,    // Header strobe from the pipe
   input  logic [vsm_hdr_pkg::DT_W-1:0]  datatype,
   input  logic [vsm_hdr_pkg::WC_W-1:0]  wordcount,
   input  logic [vsm_hdr_pkg::LC_W-1:0]  linecount,
   input  logic                          full,         // FIFO full, header is dropped
   output logic                          wr_en,
   output logic [vsm_hdr_pkg::REC_W-1:0] wr_data
);
   import vsm_hdr_pkg::*;

   logic [REC_W-1:0] rec;                                // Packed record, not yet registered

   // ========================================
   // Record packing
   // ========================================
   always_comb begin
      rec                    = '0;
      rec[LC_LSB +: LC_W]    = linecount;                // Low linecount bits
      rec[WC_LSB +: WC_W]    = wordcount;
      rec[DT_LSB +: DT_W]    = datatype;
   end

   // Write strobe one cycle after the header
   always_ff @(posedge aggre_clk) begin
      if (!rst_n) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= header_en & ~full;                     // No room, header lost
      end
   end

   // Payload register, follows the strobe
   always_ff @(posedge aggre_clk) begin
      if (header_en) begin
         wr_data <= rec;
      end
   end

endmodule

//--- design/status_fifo.sv
module status_fifo (
   input  logic                          aggre_clk,
   input  logic                          rst_n,
   input  logic                          wr_en,
   input  logic [vsm_hdr_pkg::REC_W-1:0] wr_data,
   input  logic                          rd_en,        // Pop, only honoured with data_vld
   input  logic                          clear,        // Flush, wins over a write
   output logic [vsm_hdr_pkg::REC_W-1:0] rd_data,      // Head word, fall-through
   output logic                          data_vld,
   output logic                          full
);
   import vsm_hdr_pkg::*;
   import vsm_ctrl_pkg::*;

   logic [REC_W-1:0]   mem [FIFO_DEPTH];                 // Record storage
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [CNT_W-1:0]   count;                            // Entries held
   logic               do_wr;
   logic               do_rd;

   assign do_wr    = wr_en & ~full;                      // Write when room
   assign do_rd    = rd_en & data_vld;                   // Pop only a real entry
   assign full     = (count == CNT_W'(FIFO_DEPTH));
   assign data_vld = (count != '0);
   assign rd_data  = mem[rd_ptr];                        // Head always on the bus

   // ========================================
   // Pointers and fill count
   // ========================================
   always_ff @(posedge aggre_clk) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;                                   // Empty on reset or flush
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;                     // Wraps at depth
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                     // Both or neither
         endcase
      end
   end

   // Storage write
   always_ff @(posedge aggre_clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

endmodule

//--- design/video_status_management.sv
module video_status_management (
   input  logic                                             aggre_clk,
   input  logic                                             rst_n,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               idi_header_en,
   input  logic [vsm_ctrl_pkg::NUM_PIPES*vsm_hdr_pkg::DT_W-1:0] idi_datatype,
   input  logic [vsm_ctrl_pkg::NUM_PIPES*vsm_hdr_pkg::WC_W-1:0] idi_wordcount,
   input  logic [vsm_ctrl_pkg::NUM_PIPES*vsm_hdr_pkg::LC_W-1:0] idi_linecount,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               pipe_concat_en,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               force_video_mask,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               auto_mask_en,
   input  logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               video_mask_restart,
   input  logic                                             video_mask_latch_reset,
   input  logic [vsm_hdr_pkg::DT_W-1:0]                     ref_datatype,
   input  logic [vsm_hdr_pkg::WC_W-1:0]                     ref_wordcount,
   input  logic [vsm_hdr_pkg::LC_W-1:0]                     ref_linecount,
   input  logic                                             check_linecount_en,
   input  logic                                             end_sch_pulse,
   output logic                                             start_sch_pulse,
   output logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               start_sch_pipe_mask_bitmap,
   output logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               start_sch_video_status_pass_bitmap,
   output logic [vsm_ctrl_pkg::NUM_PIPES-1:0]               pipe_mem_clear
);
   import vsm_hdr_pkg::*;
   import vsm_ctrl_pkg::*;

   logic [NUM_PIPES-1:0]       buf_wr_en;                // Capture to FIFO
   logic [NUM_PIPES*REC_W-1:0] buf_wr_data;
   logic [NUM_PIPES-1:0]       buf_full;
   logic [NUM_PIPES-1:0]       buf_data_vld;             // FIFO to mask controller
   logic [NUM_PIPES*REC_W-1:0] buf_rd_data;
   logic [NUM_PIPES-1:0]       buf_rd_en;

   // ========================================
   // Capture and FIFO per pipe
   // ========================================
   for (genvar i = 0; i < NUM_PIPES; i++) begin : g_pipe
      status_capture u_status_capture (
         .aggre_clk (aggre_clk),
         .rst_n     (rst_n),
         .header_en (idi_header_en[i]),
         .datatype  (idi_datatype[i*DT_W +: DT_W]),
         .wordcount (idi_wordcount[i*WC_W +: WC_W]),
         .linecount (idi_linecount[i*LC_W +: LC_W]),
         .full      (buf_full[i]),
         .wr_en     (buf_wr_en[i]),
         .wr_data   (buf_wr_data[i*REC_W +: REC_W])
      );

      status_fifo u_status_fifo (
         .aggre_clk (aggre_clk),
         .rst_n     (rst_n),
         .wr_en     (buf_wr_en[i]),
         .wr_data   (buf_wr_data[i*REC_W +: REC_W]),
         .rd_en     (buf_rd_en[i]),
         .clear     (pipe_mem_clear[i]),                 // Flush on new auto-mask
         .rd_data   (buf_rd_data[i*REC_W +: REC_W]),
         .data_vld  (buf_data_vld[i]),
         .full      (buf_full[i])
      );
   end

   // ========================================
   // Schedule-time check and masking
   // ========================================
   pipe_mask_ctrl u_pipe_mask_ctrl (
      .aggre_clk                (aggre_clk),
      .rst_n                    (rst_n),
      .data_vld                 (buf_data_vld),
      .rd_data                  (buf_rd_data),
      .pipe_concat_en           (pipe_concat_en),
      .force_video_mask         (force_video_mask),
      .auto_mask_en             (auto_mask_en),
      .video_mask_restart       (video_mask_restart),
      .video_mask_latch_reset   (video_mask_latch_reset),
      .ref_datatype             (ref_datatype),
      .ref_wordcount            (ref_wordcount),
      .ref_linecount            (ref_linecount),
      .check_linecount_en       (check_linecount_en),
      .end_sch_pulse            (end_sch_pulse),
      .rd_en                    (buf_rd_en),
      .mem_clear                (pipe_mem_clear),
      .start_sch_pulse          (start_sch_pulse),
      .pipe_mask_bitmap         (start_sch_pipe_mask_bitmap),
      .video_status_pass_bitmap (start_sch_video_status_pass_bitmap)
   );

endmodule

//--- design/vsm_ctrl_pkg.sv
package vsm_ctrl_pkg;

   // ========================================
   // Pipe count and FIFO geometry
   // ========================================
   localparam int NUM_PIPES  = 4;                 // Camera pipes
   localparam int FIFO_DEPTH = 4;                 // Records per pipe FIFO
   localparam int FIFO_AW    = 2;                 // Pointer width
   localparam int CNT_W      = FIFO_AW + 1;       // Fill count, holds 0..DEPTH

endpackage

//--- design/vsm_hdr_pkg.sv
package vsm_hdr_pkg;

   // ========================================
   // Packet header record fields
   // ========================================
   localparam int DT_W  = 6;                      // Datatype width
   localparam int WC_W  = 16;                     // Wordcount width
   localparam int LC_W  = 3;                      // Low linecount bits kept

   localparam int REC_W = DT_W + WC_W + LC_W;     // Full record, 25 bits

   // ========================================
   // Bit positions inside the record
   // ========================================
   // Layout from LSB upward: linecount, wordcount, datatype
   localparam int LC_LSB = 0;                     // Linecount at the bottom
   localparam int WC_LSB = LC_LSB + LC_W;         // Wordcount above it
   localparam int DT_LSB = WC_LSB + WC_W;         // Datatype on top

endpackage

//--- sim.f
design/vsm_hdr_pkg.sv
design/vsm_ctrl_pkg.sv
design/status_capture.sv
design/status_fifo.sv
design/pipe_mask_ctrl.sv
design/video_status_management.sv
sim/vsm_props.sv
sim/tb_clk_gen.sv
sim/tb_top.sv

//--- sim/tb_clk_gen.sv
module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                             // 8 unit period
   end

   // Reset low over the first three rising edges
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

//--- sim/tb_top.sv
module tb_top;
   import vsm_hdr_pkg::*;
   import vsm_ctrl_pkg::*;

   logic                      clk;
   logic                      rst_n;
   logic [NUM_PIPES-1:0]      idi_header_en;
   logic [NUM_PIPES*DT_W-1:0] idi_datatype;
   logic [NUM_PIPES*WC_W-1:0] idi_wordcount;
   logic [NUM_PIPES*LC_W-1:0] idi_linecount;
   logic [NUM_PIPES-1:0]      pipe_concat_en;
   logic [NUM_PIPES-1:0]      force_video_mask;
   logic [NUM_PIPES-1:0]      auto_mask_en;
   logic [NUM_PIPES-1:0]      video_mask_restart;
   logic                      video_mask_latch_reset;
   logic [DT_W-1:0]           ref_datatype;
   logic [WC_W-1:0]           ref_wordcount;
   logic [LC_W-1:0]           ref_linecount;
   logic                      check_linecount_en;
   logic                      end_sch_pulse;
   logic                      start_sch_pulse;
   logic [NUM_PIPES-1:0]      mask_bm;
   logic [NUM_PIPES-1:0]      pass_bm;
   logic [NUM_PIPES-1:0]      mem_clr;

   logic [15:0]          lfsr;                           // Random source state
   logic [REC_W-1:0]     model_q [NUM_PIPES][$];         // Expected FIFO contents
   logic [NUM_PIPES-1:0] model_latch;                    // Expected auto-mask latches
   logic [NUM_PIPES-1:0] exp_mask;
   logic [NUM_PIPES-1:0] exp_pass;
   logic [DT_W-1:0]      r_dt;                           // Reference values
   logic [WC_W-1:0]      r_wc;
   logic [LC_W-1:0]      r_lc;

   tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   video_status_management uut (
      .aggre_clk                          (clk),
      .rst_n                              (rst_n),
      .idi_header_en                      (idi_header_en),
      .idi_datatype                       (idi_datatype),
      .idi_wordcount                      (idi_wordcount),
      .idi_linecount                      (idi_linecount),
      .pipe_concat_en                     (pipe_concat_en),
      .force_video_mask                   (force_video_mask),
      .auto_mask_en                       (auto_mask_en),
      .video_mask_restart                 (video_mask_restart),
      .video_mask_latch_reset             (video_mask_latch_reset),
      .ref_datatype                       (ref_datatype),
      .ref_wordcount                      (ref_wordcount),
      .ref_linecount                      (ref_linecount),
      .check_linecount_en                 (check_linecount_en),
      .end_sch_pulse                      (end_sch_pulse),
      .start_sch_pulse                    (start_sch_pulse),
      .start_sch_pipe_mask_bitmap         (mask_bm),
      .start_sch_video_status_pass_bitmap (pass_bm),
      .pipe_mem_clear                     (mem_clr)
   );

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_val(input string name, input logic [NUM_PIPES-1:0] got,
                            input logic [NUM_PIPES-1:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic idle(input int n);
      for (int k = 0; k < n; k++) begin
         @(posedge clk);
         idi_header_en <= '0;                            // No header this cycle
      end
   endtask

   task automatic put_header(input int i, input logic [DT_W-1:0] dt,
                             input logic [WC_W-1:0] wc, input logic [LC_W-1:0] lc);
      idi_datatype[i*DT_W +: DT_W]  <= dt;
      idi_wordcount[i*WC_W +: WC_W] <= wc;
      idi_linecount[i*LC_W +: LC_W] <= lc;
      model_q[i].push_back({dt, wc, lc});                // Datatype high and linecount low
   endtask

   // One header cycle with the same record on each selected pipe
   task automatic send_records(input logic [NUM_PIPES-1:0] sel, input logic [DT_W-1:0] dt,
                               input logic [WC_W-1:0] wc, input logic [LC_W-1:0] lc);
      @(posedge clk);
      for (int i = 0; i < NUM_PIPES; i++) begin
         if (sel[i]) put_header(i, dt, wc, lc);
      end
      idi_header_en <= sel;
   endtask

   task automatic send_random();
      logic [NUM_PIPES-1:0] sel;
      logic [1:0]           kind;
      logic [DT_W-1:0]      dt;
      logic [WC_W-1:0]      wc;
      logic [LC_W-1:0]      lc;
      @(posedge clk);
      sel = '0;
      for (int i = 0; i < NUM_PIPES; i++) begin
         if (rand_bits(1) != 0 && model_q[i].size() < FIFO_DEPTH) begin   // Never overfill
            kind = 2'(rand_bits(2));
            dt   = r_dt;
            wc   = r_wc;
            lc   = r_lc;
            if (kind == 2'd2) lc = LC_W'(rand_bits(LC_W));
            if (kind == 2'd3) begin
               if (rand_bits(1) != 0) dt = DT_W'(rand_bits(DT_W));
               else wc = WC_W'(rand_bits(WC_W));
            end
            sel[i] = 1'b1;
            put_header(i, dt, wc, lc);
         end
      end
      idi_header_en <= sel;
   endtask

   task automatic set_refs();
      @(posedge clk);
      ref_datatype  <= r_dt;
      ref_wordcount <= r_wc;
      ref_linecount <= r_lc;
   endtask

   // ========================================
   // Schedule with model prediction
   // ========================================
   task automatic run_schedule(input logic [NUM_PIPES-1:0] concat, force_m, auto_m, restart,
                               input logic lreset, input logic chk_lc);
      logic [NUM_PIPES-1:0] exp_clr;
      logic [REC_W-1:0]     head;
      logic                 pass;
      logic                 nxt;
      int                   waited;
      idle(4);                                           // Headers settled in the FIFOs
      @(negedge clk);                                    // Bitmaps held since last time
      check_val("start_sch_pulse", NUM_PIPES'(start_sch_pulse), '0);
      check_val("pipe_mem_clear", mem_clr, '0);
      check_val("start_sch_pipe_mask_bitmap", mask_bm, exp_mask);
      check_val("start_sch_video_status_pass_bitmap", pass_bm, exp_pass);
      for (int i = 0; i < NUM_PIPES; i++) begin
         pass = 1'b0;
         if (concat[i] && model_q[i].size() > 0) begin
            head = model_q[i].pop_front();
            pass = (head[DT_LSB +: DT_W] == r_dt) && (head[WC_LSB +: WC_W] == r_wc) &&
                   (!chk_lc || head[LC_LSB +: LC_W] == r_lc);
         end
         nxt = (model_latch[i] | (concat[i] & auto_m[i] & ~pass)) &
               ~((concat[i] & restart[i]) | lreset);     // Clear beats set
         exp_clr[i]     = nxt & ~model_latch[i];
         model_latch[i] = nxt;
         exp_mask[i]    = (concat[i] & force_m[i]) | nxt;
         exp_pass[i]    = pass;
         if (exp_clr[i]) model_q[i].delete();            // Flushed by mem_clear
      end
      @(posedge clk);
      pipe_concat_en         <= concat;
      force_video_mask       <= force_m;
      auto_mask_en           <= auto_m;
      video_mask_restart     <= restart;
      video_mask_latch_reset <= lreset;
      check_linecount_en     <= chk_lc;
      end_sch_pulse          <= 1'b1;
      @(posedge clk);
      end_sch_pulse          <= 1'b0;
      video_mask_restart     <= '0;
      video_mask_latch_reset <= 1'b0;
      waited = 0;
      @(negedge clk);
      while (start_sch_pulse !== 1'b1) begin
         if (waited == 16) begin
            $display("Timeout, start_sch_pulse never came after end_sch_pulse");
            $display("Simulation finished: FAIL");
            $fatal(1, "start_sch_pulse timeout");
         end
         @(negedge clk);
         waited++;
      end
      check_val("start_sch_pipe_mask_bitmap", mask_bm, exp_mask);
      check_val("start_sch_video_status_pass_bitmap", pass_bm, exp_pass);
      check_val("pipe_mem_clear", mem_clr, exp_clr);
      idle(3);                                           // Quiet while the flush lands
   endtask

   // ========================================
   // Test sequence
   // ========================================
   initial begin
      int                   waited;
      int                   n_hdr;
      logic [NUM_PIPES-1:0] c;
      logic [NUM_PIPES-1:0] f;
      logic [NUM_PIPES-1:0] a;
      logic [NUM_PIPES-1:0] r;
      idi_header_en          <= '0;
      idi_datatype           <= '0;
      idi_wordcount          <= '0;
      idi_linecount          <= '0;
      pipe_concat_en         <= '0;
      force_video_mask       <= '0;
      auto_mask_en           <= '0;
      video_mask_restart     <= '0;
      video_mask_latch_reset <= 1'b0;
      check_linecount_en     <= 1'b0;
      end_sch_pulse          <= 1'b0;
      lfsr        = 16'd82;
      model_latch = '0;
      exp_mask    = '0;
      exp_pass    = '0;
      r_dt        = 6'h2B;
      r_wc        = 16'h0780;
      r_lc        = 3'd5;
      ref_datatype  <= r_dt;
      ref_wordcount <= r_wc;
      ref_linecount <= r_lc;

      waited = 0;
      @(negedge clk);
      while (rst_n !== 1'b1) begin
         if (waited == 20) begin
            $display("Timeout, reset never released");
            $display("Simulation finished: FAIL");
            $fatal(1, "reset timeout");
         end
         @(negedge clk);
         waited++;
      end
      check_val("start_sch_pulse", NUM_PIPES'(start_sch_pulse), '0);
      check_val("pipe_mem_clear", mem_clr, '0);
      check_val("start_sch_pipe_mask_bitmap", mask_bm, '0);
      check_val("start_sch_video_status_pass_bitmap", pass_bm, '0);

      send_records(4'hF, r_dt, r_wc, r_lc);              // All match
      run_schedule(4'hF, '0, '0, '0, 1'b0, 1'b1);
      send_records(4'b0001, r_dt ^ 6'h01, r_wc, r_lc);   // Datatype off by one bit
      send_records(4'b0010, r_dt, r_wc ^ 16'h0100, r_lc);
      send_records(4'b1100, r_dt, r_wc, r_lc);
      run_schedule(4'hF, '0, '0, '0, 1'b0, 1'b1);
      send_records(4'hF, r_dt, r_wc, r_lc ^ 3'd2);       // Linecount only
      run_schedule(4'hF, '0, '0, '0, 1'b0, 1'b0);
      send_records(4'hF, r_dt, r_wc, r_lc ^ 3'd2);
      run_schedule(4'hF, '0, '0, '0, 1'b0, 1'b1);
      send_records(4'hF, r_dt, r_wc, r_lc);
      run_schedule(4'b0101, '0, '0, '0, 1'b0, 1'b1);     // Pipes 1 and 3 keep theirs
      run_schedule(4'hF, '0, '0, '0, 1'b0, 1'b1);
      run_schedule(4'hF, '0, '0, '0, 1'b0, 1'b1);        // All empty

      // Auto-mask set, hold, restart and latch reset
      send_records(4'b0100, r_dt ^ 6'h04, r_wc, r_lc);
      send_records(4'b0100, r_dt, r_wc, r_lc);
      send_records(4'b1011, r_dt, r_wc, r_lc);
      run_schedule(4'hF, 4'b0001, 4'b0100, '0, 1'b0, 1'b1);
      send_records(4'b0100, r_dt, r_wc, r_lc);
      run_schedule(4'hF, '0, 4'b0100, '0, 1'b0, 1'b1);
      run_schedule(4'hF, '0, 4'b0100, 4'b0100, 1'b0, 1'b1);
      run_schedule(4'hF, '0, 4'hF, '0, 1'b0, 1'b1);
      run_schedule(4'hF, '0, '0, '0, 1'b1, 1'b1);

      // Long random run
      for (int it = 0; it < 300; it++) begin
         if (it % 64 == 0) begin
            r_dt = DT_W'(rand_bits(DT_W));
            r_wc = WC_W'(rand_bits(WC_W));
            r_lc = LC_W'(rand_bits(LC_W));
            set_refs();
         end
         n_hdr = int'(rand_bits(2));
         for (int h = 0; h < n_hdr; h++) send_random();
         c = NUM_PIPES'(rand_bits(NUM_PIPES));
         c = c | NUM_PIPES'(rand_bits(NUM_PIPES));      // Mostly enabled
         f = NUM_PIPES'(rand_bits(NUM_PIPES));
         f = f & NUM_PIPES'(rand_bits(NUM_PIPES));
         a = NUM_PIPES'(rand_bits(NUM_PIPES));
         r = NUM_PIPES'(rand_bits(NUM_PIPES));
         r = r & NUM_PIPES'(rand_bits(NUM_PIPES));
         run_schedule(c, f, a, r, rand_bits(3) == 0, rand_bits(1) != 0);
      end

      idle(2);
      if (uut.u_pipe_mask_ctrl.u_vsm_props.fail_cnt == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("Assertion failures seen in the mask controller");
         $display("Simulation finished: FAIL");
         $fatal(1, "assertion failures in the mask controller");
      end
   end

endmodule

//--- sim/vsm_props.sv
module vsm_props (
   input logic                              aggre_clk,
   input logic                              rst_n,
   input logic                              end_sch_pulse,
   input logic                              start_sch_pulse,
   input logic [vsm_ctrl_pkg::NUM_PIPES-1:0] data_vld,
   input logic [vsm_ctrl_pkg::NUM_PIPES-1:0] rd_en,
   input logic [vsm_ctrl_pkg::NUM_PIPES-1:0] mem_clear
);

   int fail_cnt = 0;                                     // Failed assertions so far

   // Start pulse exactly one cycle after the end pulse
   a_start_after_end: assert property (@(posedge aggre_clk) disable iff (!rst_n)
      end_sch_pulse |=> start_sch_pulse)
   else begin
      fail_cnt++;
      $error("start_sch_pulse missing one cycle after end_sch_pulse");
   end

   a_start_only_after_end: assert property (@(posedge aggre_clk) disable iff (!rst_n)
      start_sch_pulse |-> $past(end_sch_pulse))
   else begin
      fail_cnt++;
      $error("start_sch_pulse without end_sch_pulse in the cycle before");
   end

   // No pop of an empty FIFO
   a_rd_needs_vld: assert property (@(posedge aggre_clk) disable iff (!rst_n)
      (rd_en & ~data_vld) == '0)
   else begin
      fail_cnt++;
      $error("rd_en asserted on a pipe without data_vld");
   end

   a_clear_with_start: assert property (@(posedge aggre_clk) disable iff (!rst_n)
      (|mem_clear) |-> start_sch_pulse)
   else begin
      fail_cnt++;
      $error("mem_clear outside a start_sch_pulse cycle");
   end

endmodule

bind pipe_mask_ctrl vsm_props u_vsm_props (
   .aggre_clk       (aggre_clk),
   .rst_n           (rst_n),
   .end_sch_pulse   (end_sch_pulse),
   .start_sch_pulse (start_sch_pulse),
   .data_vld        (data_vld),
   .rd_en           (rd_en),
   .mem_clear       (mem_clear)
);
